// ==== logic/videoTxPkg.sv ====
/*
 * Shared definitions for the parallel RGB video transmitter.
 * Holds the display timing, the register map, the vector types and the
 * sync state encoding. Modules reach them by scoped names.
 */
package videoTxPkg;

	// Timing --------------------
	// Horizontal timing in pixel clocks
	localparam int hActive = 16;
	localparam int hFront = 2;
	localparam int hSync = 3;
	localparam int hBack = 3;
	localparam int hTotal = 24;
	// Vertical timing in lines
	localparam int vActive = 8;
	localparam int vFront = 1;
	localparam int vSync = 2;
	localparam int vBack = 1;
	localparam int vTotal = 12;

	// Line FIFO depth, also the start credit
	localparam int fifoDepth = 32;
	localparam int regAddrWidth = 2;

	// Register map --------------------
	localparam int regCtrl = 0;
	localparam int regColor = 1;
	localparam int regStatus = 2;
	localparam int regFrames = 3;

	// Types --------------------
	typedef logic [15:0] pixel565_t;
	// R in the high byte
	typedef logic [23:0] rgb888_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;
	typedef logic [15:0] regData_t;
	typedef logic [4:0] hCount_t;
	typedef logic [3:0] vCount_t;
	typedef logic [5:0] credit_t;

	// Vertical phase of the sync generator
	typedef enum logic [2:0] {
		sIdle,
		sSync,
		sBack,
		sActive,
		sFront
	} syncState_t;

endpackage

// ==== logic/videoTxIf.sv ====
/*
 * Links between the transmitter blocks.
 * cfgIf carries control from the register block and events back to it.
 * pixIf carries the pixel stream under credit flow control.
 */
`timescale 1ns/1ns

interface cfgIf;
	// From the register block
	logic enable;
	logic gradient;
	videoTxPkg::pixel565_t sceneColor;
	// Single-cycle events from the sync generator
	logic frameDone;
	logic underrun;

	modport csr (
		output enable,
		output gradient,
		output sceneColor,
		input frameDone,
		input underrun
	);

	// Seen by the generator and the sync block
	modport core (
		input enable,
		input gradient,
		input sceneColor,
		output frameDone,
		output underrun
	);
endinterface

interface pixIf;
	// Source may only send with a credit in hand
	logic pixValid;
	videoTxPkg::pixel565_t pixData;
	// One pulse per entry freed in the sink
	logic creditReturn;

	modport source (
		output pixValid,
		output pixData,
		input creditReturn
	);

	modport sink (
		input pixValid,
		input pixData,
		output creditReturn
	);
endinterface

// ==== logic/videoTxCsr.sv ====
/*
 * Register block of the video transmitter.
 * Written over a simple address/data bus, read data comes back one
 * cycle after the address. Holds enable, pattern mode and scene colour,
 * and reports the frame counter and the sticky underrun flag.
 */
`timescale 1ns/1ns

module videoTxCsr (
	input logic iVCLK,
	input logic iVRST,
	input videoTxPkg::regAddr_t regAddr,
	input videoTxPkg::regData_t regWdata,
	input logic regWrite,
	output videoTxPkg::regData_t regRdata,
	cfgIf.csr cfg
);

	logic enableReg;
	logic gradientReg;
	videoTxPkg::pixel565_t colorReg;
	videoTxPkg::regData_t frameCount;
	logic underrunFlag;

	// Write side --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			enableReg <= 1'b0;
			gradientReg <= 1'b0;
			colorReg <= '0;
			frameCount <= '0;
			underrunFlag <= 1'b0;
		end
		else
		begin
			if (regWrite && regAddr == videoTxPkg::regCtrl)
			begin
				enableReg <= regWdata[0];
				gradientReg <= regWdata[1];
			end
			if (regWrite && regAddr == videoTxPkg::regColor)
				colorReg <= regWdata;
			// Counter wraps at 16 bits
			if (cfg.frameDone)
				frameCount <= frameCount + 16'd1;
			// New underrun wins over a clear in the same cycle
			if (cfg.underrun)
				underrunFlag <= 1'b1;
			else if (regWrite && regAddr == videoTxPkg::regStatus && regWdata[0])
				underrunFlag <= 1'b0;
		end
	end

	// Registered read mux --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			regRdata <= '0;
		else
		begin
			case (regAddr)
				videoTxPkg::regCtrl: regRdata <= {14'd0, gradientReg, enableReg};
				videoTxPkg::regColor: regRdata <= colorReg;
				videoTxPkg::regStatus: regRdata <= {15'd0, underrunFlag};
				default: regRdata <= frameCount;
			endcase
		end
	end

	// Control fields out to the datapath
	assign cfg.enable = enableReg;
	assign cfg.gradient = gradientReg;
	assign cfg.sceneColor = colorReg;

endmodule

// ==== logic/scenePixelGen.sv ====
/*
 * Scene pixel generator for the active area.
 * Emits RGB565 pixels in raster order, solid colour or a horizontal
 * gradient of colour plus column. Sends only while it holds credits.
 */
`timescale 1ns/1ns

module scenePixelGen (
	input logic iVCLK,
	input logic iVRST,
	cfgIf.core cfg,
	pixIf.source pix
);

	logic running;
	videoTxPkg::hCount_t x;
	videoTxPkg::vCount_t y;
	videoTxPkg::credit_t credits;
	logic lastX;
	logic lastY;

	assign lastX = x == videoTxPkg::hActive - 1;
	assign lastY = y == videoTxPkg::vActive - 1;

	// Stream out --------------------
	// No credit means stall with x and y held
	assign pix.pixValid = running && (credits != '0);
	// Gradient adds the column with a 16-bit wrap
	assign pix.pixData = cfg.gradient ? cfg.sceneColor + videoTxPkg::pixel565_t'(x)
		: cfg.sceneColor;

	// Credit counter
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			credits <= videoTxPkg::credit_t'(videoTxPkg::fifoDepth);
		else if (pix.pixValid && !pix.creditReturn)
			credits <= credits - 6'd1;
		else if (!pix.pixValid && pix.creditReturn)
			credits <= credits + 6'd1;
	end

	// Raster walk --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			running <= 1'b0;
			x <= '0;
			y <= '0;
		end
		else if (!running)
		begin
			// Idle until enable, then restart at the origin
			if (cfg.enable)
			begin
				running <= 1'b1;
				x <= '0;
				y <= '0;
			end
		end
		else if (pix.pixValid)
		begin
			if (lastX)
			begin
				x <= '0;
				if (lastY)
				begin
					y <= '0;
					// Frame done, carry on only if still enabled
					running <= cfg.enable;
				end
				else
					y <= y + 4'd1;
			end
			else
				x <= x + 5'd1;
		end
	end

endmodule

// ==== logic/lineFifo.sv ====
/*
 * Synchronous line FIFO between the pixel generator and the sync block.
 * Push is the credit stream, pop is show-ahead. Every pop returns one
 * credit to the source, so the buffer never overflows.
 */
`timescale 1ns/1ns

module lineFifo (
	input logic iVCLK,
	input logic iVRST,
	pixIf.sink pix,
	input logic popEn,
	output videoTxPkg::pixel565_t popData,
	output logic fifoEmpty
);

	videoTxPkg::pixel565_t mem [videoTxPkg::fifoDepth];
	logic [$clog2(videoTxPkg::fifoDepth)-1:0] wrPtr;
	logic [$clog2(videoTxPkg::fifoDepth)-1:0] rdPtr;
	videoTxPkg::credit_t fill;
	logic popFire;

	// Pop on an empty buffer is dropped
	assign popFire = popEn && !fifoEmpty;
	assign fifoEmpty = fill == '0;
	assign popData = mem[rdPtr];
	assign pix.creditReturn = popFire;

	// Storage
	always_ff @(posedge iVCLK)
	begin
		if (pix.pixValid)
			mem[wrPtr] <= pix.pixData;
	end

	// Pointers and fill level --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
		end
		else
		begin
			if (pix.pixValid)
				wrPtr <= wrPtr + 1'b1;
			if (popFire)
				rdPtr <= rdPtr + 1'b1;
			if (pix.pixValid && !popFire)
				fill <= fill + 6'd1;
			else if (!pix.pixValid && popFire)
				fill <= fill - 6'd1;
		end
	end

endmodule

// ==== logic/videoSyncGen.sv ====
/*
 * Sync generator for the RGB output.
 * Runs the line and frame counters, makes HS, VS, DE and FE, pops one
 * pixel per DE cycle and expands it to RGB888. All outputs are
 * registered one cycle behind the counters.
 */
`timescale 1ns/1ns

module videoSyncGen (
	input logic iVCLK,
	input logic iVRST,
	cfgIf.core cfg,
	output logic popEn,
	input videoTxPkg::pixel565_t popData,
	input logic fifoEmpty,
	output videoTxPkg::rgb888_t videoRgb,
	output logic videoHs,
	output logic videoVs,
	output logic videoDe,
	output logic videoFe
);

	videoTxPkg::syncState_t state;
	videoTxPkg::syncState_t nextPhase;
	videoTxPkg::hCount_t hCount;
	videoTxPkg::vCount_t vCount;
	logic lineEnd;
	logic phaseEnd;
	logic hsNow;
	logic vsNow;
	logic deNow;
	logic feNow;

	// Line layout is sync, back porch, active, front porch
	assign lineEnd = hCount == videoTxPkg::hTotal - 1;
	assign hsNow = (state != videoTxPkg::sIdle) && (hCount < videoTxPkg::hSync);
	assign vsNow = state == videoTxPkg::sSync;
	assign deNow = (state == videoTxPkg::sActive)
		&& (hCount >= videoTxPkg::hSync + videoTxPkg::hBack)
		&& (hCount < videoTxPkg::hSync + videoTxPkg::hBack + videoTxPkg::hActive);
	// Last active pixel of the last active line
	assign feNow = deNow && (vCount == videoTxPkg::vActive - 1)
		&& (hCount == videoTxPkg::hSync + videoTxPkg::hBack + videoTxPkg::hActive - 1);

	// Vertical phase bookkeeping --------------------
	always_comb
	begin
		phaseEnd = 1'b0;
		nextPhase = videoTxPkg::sIdle;
		case (state)
			videoTxPkg::sSync:
			begin
				phaseEnd = vCount == videoTxPkg::vSync - 1;
				nextPhase = videoTxPkg::sBack;
			end
			videoTxPkg::sBack:
			begin
				phaseEnd = vCount == videoTxPkg::vBack - 1;
				nextPhase = videoTxPkg::sActive;
			end
			videoTxPkg::sActive:
			begin
				phaseEnd = vCount == videoTxPkg::vActive - 1;
				nextPhase = videoTxPkg::sFront;
			end
			videoTxPkg::sFront:
			begin
				phaseEnd = vCount == videoTxPkg::vFront - 1;
				// Frame ends here, stop if enable went away
				nextPhase = cfg.enable ? videoTxPkg::sSync : videoTxPkg::sIdle;
			end
			default:
			begin
				phaseEnd = 1'b0;
				nextPhase = videoTxPkg::sIdle;
			end
		endcase
	end

	// Counters and state
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			state <= videoTxPkg::sIdle;
			hCount <= '0;
			vCount <= '0;
		end
		else if (state == videoTxPkg::sIdle)
		begin
			if (cfg.enable)
			begin
				state <= videoTxPkg::sSync;
				hCount <= '0;
				vCount <= '0;
			end
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			if (phaseEnd)
			begin
				vCount <= '0;
				state <= nextPhase;
			end
			else
				vCount <= vCount + 4'd1;
		end
		else
			hCount <= hCount + 5'd1;
	end

	// FIFO side and events --------------------
	assign popEn = deNow;
	assign cfg.frameDone = feNow;
	assign cfg.underrun = deNow && fifoEmpty;

	// Registered video outputs
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			videoHs <= 1'b0;
			videoVs <= 1'b0;
			videoDe <= 1'b0;
			videoFe <= 1'b0;
			videoRgb <= '0;
		end
		else
		begin
			videoHs <= hsNow;
			videoVs <= vsNow;
			videoDe <= deNow;
			videoFe <= feNow;
			// Zero padded RGB565, black on blanking or underrun
			if (deNow && !fifoEmpty)
				videoRgb <= {popData[15:11], 3'b000, popData[10:5], 2'b00,
					popData[4:0], 3'b000};
			else
				videoRgb <= '0;
		end
	end

endmodule

// ==== logic/videoTx.sv ====
/*
 * Top level of the parallel RGB video transmitter.
 * Register bus and video pins as plain ports. Inside, the register
 * block, pixel generator, line FIFO and sync generator are linked.
 */
`timescale 1ns/1ns

module videoTx (
	input logic iVCLK,
	input logic iVRST,
	input videoTxPkg::regAddr_t regAddr,
	input videoTxPkg::regData_t regWdata,
	input logic regWrite,
	output videoTxPkg::regData_t regRdata,
	output logic [7:0] videoR,
	output logic [7:0] videoG,
	output logic [7:0] videoB,
	output logic videoHs,
	output logic videoVs,
	output logic videoDe,
	output logic videoFe
);

	// Internal links
	cfgIf cfgLink ();
	pixIf pixLink ();

	logic popEn;
	videoTxPkg::pixel565_t popData;
	logic fifoEmpty;
	videoTxPkg::rgb888_t videoRgb;

	// Blocks --------------------
	videoTxCsr csr (
		.iVCLK(iVCLK),
		.iVRST(iVRST),
		.regAddr(regAddr),
		.regWdata(regWdata),
		.regWrite(regWrite),
		.regRdata(regRdata),
		.cfg(cfgLink.csr)
	);

	scenePixelGen pixelGen (
		.iVCLK(iVCLK),
		.iVRST(iVRST),
		.cfg(cfgLink.core),
		.pix(pixLink.source)
	);

	lineFifo fifo (
		.iVCLK(iVCLK),
		.iVRST(iVRST),
		.pix(pixLink.sink),
		.popEn(popEn),
		.popData(popData),
		.fifoEmpty(fifoEmpty)
	);

	videoSyncGen syncGen (
		.iVCLK(iVCLK),
		.iVRST(iVRST),
		.cfg(cfgLink.core),
		.popEn(popEn),
		.popData(popData),
		.fifoEmpty(fifoEmpty),
		.videoRgb(videoRgb),
		.videoHs(videoHs),
		.videoVs(videoVs),
		.videoDe(videoDe),
		.videoFe(videoFe)
	);

	// Split into channel pins, R in the high byte
	assign videoR = videoRgb[23:16];
	assign videoG = videoRgb[15:8];
	assign videoB = videoRgb[7:0];

endmodule

// ==== dv/videoTx_assertions.sv ====
/*
 * Concurrent checks on the video pins of the transmitter top level.
 * Bound into every videoTx instance.
 */
`timescale 1ns/1ns

module videoTxAssertions (
	input logic iVCLK,
	input logic iVRST,
	input logic videoHs,
	input logic videoVs,
	input logic videoDe,
	input logic videoFe,
	input logic [7:0] videoR,
	input logic [7:0] videoG,
	input logic [7:0] videoB
);

	// Active data never overlaps a sync pulse
	deOutsideSync: assert property (@(posedge iVCLK) disable iff (iVRST)
		videoDe |-> !(videoHs || videoVs))
		else $error("DE high together with HS or VS");

	// Frame end marks the last active pixel
	feOnDe: assert property (@(posedge iVCLK) disable iff (iVRST)
		videoFe |-> videoDe)
		else $error("FE high without DE");

	// Blanking is black
	blankIsBlack: assert property (@(posedge iVCLK) disable iff (iVRST)
		!videoDe |-> (videoR == 8'd0 && videoG == 8'd0 && videoB == 8'd0))
		else $error("RGB not black while DE is low");

endmodule

bind videoTx videoTxAssertions assertions (
	.iVCLK(iVCLK),
	.iVRST(iVRST),
	.videoHs(videoHs),
	.videoVs(videoVs),
	.videoDe(videoDe),
	.videoFe(videoFe),
	.videoR(videoR),
	.videoG(videoG),
	.videoB(videoB)
);

// ==== dv/videoTxTb.sv ====
/*
 * Testbench for the video transmitter.
 * Checks reset values and register readback, then runs one solid frame
 * and two gradient frames while a monitor compares every DE pixel and
 * the sync structure against a reference model. Stops at the first error.
 */
`timescale 1ns/1ns

module videoTxTb;

	localparam int clkPeriod = 8;
	// Six frames of pixel clocks plus slack for the register traffic
	localparam int watchdogNs = 6 * videoTxPkg::hTotal * videoTxPkg::vTotal * clkPeriod + 2000;
	// Rest of the last line plus the front porch until the FSM idles
	localparam int idleWait = videoTxPkg::hFront + videoTxPkg::vFront * videoTxPkg::hTotal + 4;

	logic iVCLK;
	logic iVRST;
	videoTxPkg::regAddr_t regAddr;
	videoTxPkg::regData_t regWdata;
	logic regWrite;
	videoTxPkg::regData_t regRdata;
	logic [7:0] videoR;
	logic [7:0] videoG;
	logic [7:0] videoB;
	logic videoHs;
	logic videoVs;
	logic videoDe;
	logic videoFe;
	videoTxPkg::rgb888_t seenRgb;

	// Scene the monitor expects, set only while the DUT is idle
	videoTxPkg::pixel565_t curColor;
	logic curGradient;
	integer seed;
	int framesRun;
	// Monitor counters
	int deCount;
	int lineCount;
	int hsLen;
	int vsLen;
	int feSeen;

	videoTx DUT (
		.iVCLK(iVCLK),
		.iVRST(iVRST),
		.regAddr(regAddr),
		.regWdata(regWdata),
		.regWrite(regWrite),
		.regRdata(regRdata),
		.videoR(videoR),
		.videoG(videoG),
		.videoB(videoB),
		.videoHs(videoHs),
		.videoVs(videoVs),
		.videoDe(videoDe),
		.videoFe(videoFe)
	);

	assign seenRgb = {videoR, videoG, videoB};

	initial
	begin
		iVCLK = 1'b0;
		forever #(clkPeriod / 2) iVCLK = ~iVCLK;
	end

	// Reference model and checks --------------------
	// RGB565 pixel, plus column in gradient mode, zero padded to RGB888
	function automatic videoTxPkg::rgb888_t expectedPixel(input videoTxPkg::pixel565_t color,
		input logic gradient, input int x);
		videoTxPkg::pixel565_t p;
		p = color;
		if (gradient)
			p = color + 16'(x);
		return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
	endfunction

	task automatic stopRun();
		$display("Something failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic reportFault(input string why);
		$display("%s", why);
		stopRun();
	endtask

	task automatic checkPixel(input string name, input videoTxPkg::rgb888_t expected,
		input videoTxPkg::rgb888_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkReg(input string name, input videoTxPkg::regData_t expected,
		input videoTxPkg::regData_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
			stopRun();
		end
	endtask

	// Register bus --------------------
	task automatic writeReg(input int addr, input videoTxPkg::regData_t data);
		@(negedge iVCLK);
		regAddr = videoTxPkg::regAddr_t'(addr);
		regWdata = data;
		regWrite = 1'b1;
		@(negedge iVCLK);
		regWrite = 1'b0;
	endtask

	// Read data is registered, one cycle after the address
	task automatic readReg(input int addr, output videoTxPkg::regData_t data);
		@(negedge iVCLK);
		regAddr = videoTxPkg::regAddr_t'(addr);
		regWrite = 1'b0;
		@(negedge iVCLK);
		data = regRdata;
	endtask

	// One frame from idle back to idle
	task automatic runFrame(input videoTxPkg::pixel565_t color, input logic gradient);
		curColor = color;
		curGradient = gradient;
		writeReg(videoTxPkg::regColor, color);
		writeReg(videoTxPkg::regCtrl, videoTxPkg::regData_t'({gradient, 1'b1}));
		while (!videoDe)
			@(negedge iVCLK);
		// Early drop so only this frame is generated
		writeReg(videoTxPkg::regCtrl, videoTxPkg::regData_t'({gradient, 1'b0}));
		while (!videoFe)
			@(negedge iVCLK);
		repeat (idleWait) @(negedge iVCLK);
		// Whole frame seen, count its lines
		checkCount("active lines", videoTxPkg::vActive, lineCount);
		lineCount = 0;
		framesRun++;
	endtask

	// Monitor --------------------
	always @(negedge iVCLK)
	begin
		if (!iVRST)
		begin
			if (videoDe)
			begin
				if (videoHs || videoVs)
					reportFault("DE was high during a sync pulse");
				checkPixel("videoRgb", expectedPixel(curColor, curGradient, deCount), seenRgb);
				if (videoFe)
				begin
					checkCount("FE column", videoTxPkg::hActive - 1, deCount);
					checkCount("FE line", videoTxPkg::vActive - 1, lineCount);
					feSeen++;
				end
				deCount++;
			end
			else
			begin
				if (videoFe)
					reportFault("FE was high while DE was low");
				checkPixel("videoRgb in blanking", '0, seenRgb);
				// Falling DE closes a line
				if (deCount != 0)
				begin
					checkCount("DE run length", videoTxPkg::hActive, deCount);
					deCount = 0;
					lineCount++;
				end
			end
			if (videoHs)
				hsLen++;
			else if (hsLen != 0)
			begin
				checkCount("HS width", videoTxPkg::hSync, hsLen);
				hsLen = 0;
			end
			// VS spans the sync lines
			if (videoVs)
				vsLen++;
			else if (vsLen != 0)
			begin
				checkCount("VS width", videoTxPkg::vSync * videoTxPkg::hTotal, vsLen);
				vsLen = 0;
			end
		end
	end

	// Watchdog
	initial
	begin
		#(watchdogNs);
		reportFault("Timeout: the video frames did not complete in time");
	end

	// Stimulus --------------------
	initial
	begin
		videoTxPkg::regData_t rd;
		videoTxPkg::pixel565_t colorA;
		videoTxPkg::pixel565_t colorB;
		iVRST = 1'b1;
		regAddr = '0;
		regWdata = '0;
		regWrite = 1'b0;
		seed = 76380;
		framesRun = 0;
		deCount = 0;
		lineCount = 0;
		hsLen = 0;
		vsLen = 0;
		feSeen = 0;
		curColor = '0;
		curGradient = 1'b0;
		repeat (3) @(negedge iVCLK);
		iVRST = 1'b0;

		// Reset values
		checkPixel("videoRgb after reset", '0, seenRgb);
		checkCount("video syncs after reset", 0, {videoHs, videoVs, videoDe, videoFe});
		readReg(videoTxPkg::regCtrl, rd);
		checkReg("regCtrl after reset", 16'h0000, rd);
		readReg(videoTxPkg::regStatus, rd);
		checkReg("regStatus after reset", 16'h0000, rd);
		readReg(videoTxPkg::regFrames, rd);
		checkReg("regFrames after reset", 16'h0000, rd);

		// Readback with video still off
		writeReg(videoTxPkg::regColor, 16'hA5C3);
		writeReg(videoTxPkg::regCtrl, 16'h0002);
		readReg(videoTxPkg::regColor, rd);
		checkReg("regColor readback", 16'hA5C3, rd);
		readReg(videoTxPkg::regCtrl, rd);
		checkReg("regCtrl readback", 16'h0002, rd);
		writeReg(videoTxPkg::regCtrl, 16'h0000);

		// Solid frame, then two gradient frames
		colorA = videoTxPkg::pixel565_t'($random(seed));
		runFrame(colorA, 1'b0);
		colorA = videoTxPkg::pixel565_t'($random(seed));
		colorB = videoTxPkg::pixel565_t'($random(seed));
		while (colorB == colorA)
			colorB = videoTxPkg::pixel565_t'($random(seed));
		runFrame(colorA, 1'b1);
		runFrame(colorB, 1'b1);

		// Status after the run
		checkCount("FE pulses", framesRun, feSeen);
		readReg(videoTxPkg::regFrames, rd);
		checkReg("regFrames", videoTxPkg::regData_t'(framesRun), rd);
		readReg(videoTxPkg::regStatus, rd);
		checkReg("regStatus", 16'h0000, rd);

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== videoTx.f ====
logic/videoTxPkg.sv
logic/videoTxIf.sv
logic/videoTxCsr.sv
logic/scenePixelGen.sv
logic/lineFifo.sv
logic/videoSyncGen.sv
logic/videoTx.sv
dv/videoTx_assertions.sv
dv/videoTxTb.sv

// ==== Bender.yml ====
package:
  name: videoTx

sources:
  - logic/videoTxPkg.sv
  - logic/videoTxIf.sv
  - logic/videoTxCsr.sv
  - logic/scenePixelGen.sv
  - logic/lineFifo.sv
  - logic/videoSyncGen.sv
  - logic/videoTx.sv
  - target: test
    files:
      - dv/videoTx_assertions.sv
      - dv/videoTxTb.sv
